//--- Bender.yml
package:
  name: l2_cache

sources:
  - source/l2_cache_pkg.sv
  - source/l2_cache_control.sv
  - source/miss_counter.sv
  - source/way_arrays.sv
  - source/plru_tree.sv
  - source/l2_cache.sv
  - target: test
    files:
      - verif/l2_cache_properties.sv
      - verif/l2_cache_tb.sv

//--- files.f
source/l2_cache_pkg.sv
source/l2_cache_control.sv
source/miss_counter.sv
source/way_arrays.sv
source/plru_tree.sv
source/l2_cache.sv
verif/l2_cache_properties.sv
verif/l2_cache_tb.sv

//--- source/l2_cache.sv
// ##########################################################
// top of the four-way write-back cache; connects the FSM,
// the miss counter, the way arrays and the pseudo-LRU tree
// ##########################################################

`timescale 1ns/10ps
`default_nettype none

module l2_cache
(
    input  logic                 clk,
    input  logic                 rst,

    // CPU side
    input  logic                 mem_read,
    input  logic                 mem_write,
    input  l2_cache_pkg::addr_t  mem_address,
    input  l2_cache_pkg::word_t  mem_wdata,
    output l2_cache_pkg::word_t  mem_rdata,
    output logic                 mem_resp,

    // memory side
    output logic                 pmem_read,
    output logic                 pmem_write,
    output l2_cache_pkg::addr_t  pmem_address,
    output l2_cache_pkg::word_t  pmem_wdata,
    input  l2_cache_pkg::word_t  pmem_rdata,
    input  logic                 pmem_resp,

    // performance
    output l2_cache_pkg::count_t miss_count,
    output logic                 miss_overflow
);

    // arrays to FSM
    logic                    hit;
    logic                    victim_dirty;
    l2_cache_pkg::tag_t      victim_tag;

    // arrays and tree
    l2_cache_pkg::way_t      hit_way;
    l2_cache_pkg::way_t      victim_way;
    l2_cache_pkg::way_mask_t valid_mask;

    // FSM strobes
    logic                    fill_en;
    logic                    write_en;
    logic                    plru_update;
    logic                    miss_event;

    l2_cache_control control0 (
        .clk          (clk),
        .rst          (rst),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_address  (mem_address),
        .mem_resp     (mem_resp),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .pmem_resp    (pmem_resp),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .fill_en      (fill_en),
        .write_en     (write_en),
        .plru_update  (plru_update),
        .miss_event   (miss_event)
    );

    miss_counter counter0 (
        .clk           (clk),
        .rst           (rst),
        .miss_event    (miss_event),
        .miss_count    (miss_count),
        .miss_overflow (miss_overflow)
    );

    // victim data goes straight out as write-back data
    way_arrays arrays0 (
        .clk          (clk),
        .rst          (rst),
        .mem_address  (mem_address),
        .mem_wdata    (mem_wdata),
        .pmem_rdata   (pmem_rdata),
        .victim_way   (victim_way),
        .fill_en      (fill_en),
        .write_en     (write_en),
        .hit          (hit),
        .hit_way      (hit_way),
        .valid_mask   (valid_mask),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_data  (pmem_wdata),
        .mem_rdata    (mem_rdata)
    );

    plru_tree plru0 (
        .clk         (clk),
        .rst         (rst),
        .mem_address (mem_address),
        .hit_way     (hit_way),
        .valid_mask  (valid_mask),
        .plru_update (plru_update),
        .victim_way  (victim_way)
    );

endmodule

`default_nettype wire

//--- source/l2_cache_control.sv
// ##########################################################
// cache controller FSM: sequences lookup, dirty write-back
// and refill, answers the CPU and forms the memory address
// ##########################################################

`timescale 1ns/10ps
`default_nettype none

module l2_cache_control
(
    input  logic                clk,
    input  logic                rst,

    // CPU side request
    input  logic                mem_read,
    input  logic                mem_write,
    input  l2_cache_pkg::addr_t mem_address,
    output logic                mem_resp,

    // lookup results from the arrays
    input  logic                hit,
    input  logic                victim_dirty,
    input  l2_cache_pkg::tag_t  victim_tag,

    // memory side
    input  logic                pmem_resp,
    output logic                pmem_read,
    output logic                pmem_write,
    output l2_cache_pkg::addr_t pmem_address,

    // array and tree steering
    output logic                fill_en,
    output logic                write_en,
    output logic                plru_update,

    // one pulse per missed lookup
    output logic                miss_event
);

    l2_cache_pkg::ctrl_state_t state;
    l2_cache_pkg::ctrl_state_t next_state;

    logic                 request;
    l2_cache_pkg::tag_t   req_tag;
    l2_cache_pkg::index_t req_index;

    assign request = mem_read | mem_write;

    // split the request address
    assign req_tag   = mem_address[31 -: l2_cache_pkg::tag_bits];
    assign req_index = mem_address[l2_cache_pkg::offset_bits +: l2_cache_pkg::index_bits];

    // victim address during write-back, request line otherwise
    // offset is always zero, a line is one word
    always_comb
    begin
        if (state == l2_cache_pkg::WRITE_BACK)
        begin
            pmem_address = {victim_tag, req_index, {l2_cache_pkg::offset_bits{1'b0}}};
        end
        else
        begin
            pmem_address = {req_tag, req_index, {l2_cache_pkg::offset_bits{1'b0}}};
        end
    end

    // state outputs
    always_comb
    begin
        mem_resp    = 1'b0;
        pmem_read   = 1'b0;
        pmem_write  = 1'b0;
        fill_en     = 1'b0;
        write_en    = 1'b0;
        plru_update = 1'b0;
        miss_event  = 1'b0;

        case (state)
            l2_cache_pkg::LOOKUP:
            begin
                if (hit)
                begin
                    // answer now, touch the tree
                    mem_resp    = 1'b1;
                    plru_update = 1'b1;
                    // write hit lands in the hit way and marks it dirty
                    write_en    = mem_write;
                end
                else
                begin
                    miss_event = 1'b1;
                end
            end

            l2_cache_pkg::WRITE_BACK:
            begin
                pmem_write = 1'b1;
            end

            l2_cache_pkg::FILL:
            begin
                pmem_read = 1'b1;
                // refill data is only valid in the resp cycle
                fill_en   = pmem_resp;
            end

            default:
            begin
            end
        endcase
    end

    // transitions
    always_comb
    begin
        next_state = state;

        case (state)
            l2_cache_pkg::IDLE:
            begin
                if (request)
                begin
                    next_state = l2_cache_pkg::LOOKUP;
                end
            end

            l2_cache_pkg::LOOKUP:
            begin
                if (hit)
                begin
                    next_state = l2_cache_pkg::IDLE;
                end
                else if (victim_dirty)
                begin
                    next_state = l2_cache_pkg::WRITE_BACK;
                end
                else
                begin
                    next_state = l2_cache_pkg::FILL;
                end
            end

            l2_cache_pkg::WRITE_BACK:
            begin
                if (pmem_resp)
                begin
                    next_state = l2_cache_pkg::FILL;
                end
            end

            l2_cache_pkg::FILL:
            begin
                // retry, the lookup hits this time
                if (pmem_resp)
                begin
                    next_state = l2_cache_pkg::LOOKUP;
                end
            end

            default:
            begin
                next_state = l2_cache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= l2_cache_pkg::IDLE;
        end
        else
        begin
            state <= next_state;
        end
    end

endmodule

`default_nettype wire

//--- source/l2_cache_pkg.sv
// ##########################################################
// shared geometry, width types and controller states for
// the four-way write-back cache; every RTL file refers to
// these by scoped name
// ##########################################################

`default_nettype none

package l2_cache_pkg;

    // cache geometry
    localparam int num_ways    = 4;
    localparam int num_sets    = 8;
    localparam int index_bits  = 3;
    // byte offset inside the word, ignored by the cache
    localparam int offset_bits = 2;
    // whatever is left of a 32-bit address
    localparam int tag_bits    = 32 - index_bits - offset_bits;

    // miss counter width
    localparam int count_bits  = 16;

    // byte address on both sides
    typedef logic [31:0] addr_t;
    // one data word, also one full line
    typedef logic [31:0] word_t;

    typedef logic [tag_bits-1:0]   tag_t;
    typedef logic [index_bits-1:0] index_t;

    // way number and one-bit-per-way mask
    typedef logic [1:0]          way_t;
    typedef logic [num_ways-1:0] way_mask_t;

    // tree bits of one set: 2 is the root, 1 covers ways 0/1,
    // 0 covers ways 2/3
    typedef logic [2:0] plru_t;

    typedef logic [count_bits-1:0] count_t;

    // controller FSM states
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        WRITE_BACK,
        FILL
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- source/miss_counter.sv
// ##########################################################
// miss performance counter; counts miss_event strobes and
// keeps a sticky flag once the count has wrapped
// ##########################################################

`timescale 1ns/10ps
`default_nettype none

module miss_counter
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 miss_event,
    output l2_cache_pkg::count_t miss_count,
    output logic                 miss_overflow
);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            miss_count    <= '0;
            miss_overflow <= 1'b0;
        end
        else if (miss_event)
        begin
            // natural wrap at the top of the count width
            miss_count <= miss_count + 1'b1;
            // stays set until reset
            if (miss_count == '1)
            begin
                miss_overflow <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/plru_tree.sv
// ##########################################################
// tree pseudo-LRU state, one three-bit entry per set;
// records the hit way and names the next victim, preferring
// the lowest invalid way
// ##########################################################

`timescale 1ns/10ps
`default_nettype none

module plru_tree
(
    input  logic                    clk,
    input  logic                    rst,
    input  l2_cache_pkg::addr_t     mem_address,
    input  l2_cache_pkg::way_t      hit_way,
    input  l2_cache_pkg::way_mask_t valid_mask,
    input  logic                    plru_update,
    output l2_cache_pkg::way_t      victim_way
);

    l2_cache_pkg::plru_t  plru_mem [l2_cache_pkg::num_sets];
    l2_cache_pkg::index_t req_index;
    l2_cache_pkg::plru_t  cur;

    assign req_index = mem_address[l2_cache_pkg::offset_bits +: l2_cache_pkg::index_bits];
    assign cur       = plru_mem[req_index];

    always_comb
    begin
        // tree points away from the recent side
        if (cur[2] == 1'b0)
        begin
            victim_way = cur[0] ? 2'd2 : 2'd3;
        end
        else
        begin
            victim_way = cur[1] ? 2'd0 : 2'd1;
        end
        // empty ways go first, lowest one
        for (int w = l2_cache_pkg::num_ways - 1; w >= 0; w--)
        begin
            if (!valid_mask[w])
            begin
                victim_way = l2_cache_pkg::way_t'(w);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < l2_cache_pkg::num_sets; s++)
            begin
                plru_mem[s] <= '0;
            end
        end
        else if (plru_update)
        begin
            // root takes the half, the leaf bit takes the way inside it
            case (hit_way)
                2'd0:    plru_mem[req_index] <= {1'b0, 1'b0, cur[0]};
                2'd1:    plru_mem[req_index] <= {1'b0, 1'b1, cur[0]};
                2'd2:    plru_mem[req_index] <= {1'b1, cur[1], 1'b0};
                default: plru_mem[req_index] <= {1'b1, cur[1], 1'b1};
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/way_arrays.sv
// ##########################################################
// tag, valid, dirty and data storage for all four ways;
// reads combinationally for hit detection and victim
// readout, writes at the clock edge on fill or write hit
// ##########################################################

`timescale 1ns/10ps
`default_nettype none

module way_arrays
(
    input  logic                      clk,
    input  logic                      rst,
    input  l2_cache_pkg::addr_t       mem_address,
    input  l2_cache_pkg::word_t       mem_wdata,
    input  l2_cache_pkg::word_t       pmem_rdata,
    input  l2_cache_pkg::way_t        victim_way,
    input  logic                      fill_en,
    input  logic                      write_en,
    output logic                      hit,
    output l2_cache_pkg::way_t        hit_way,
    output l2_cache_pkg::way_mask_t   valid_mask,
    output logic                      victim_dirty,
    output l2_cache_pkg::tag_t        victim_tag,
    output l2_cache_pkg::word_t       victim_data,
    output l2_cache_pkg::word_t       mem_rdata
);

    // storage, indexed [set][way]
    l2_cache_pkg::tag_t  tag_mem   [l2_cache_pkg::num_sets][l2_cache_pkg::num_ways];
    l2_cache_pkg::word_t data_mem  [l2_cache_pkg::num_sets][l2_cache_pkg::num_ways];
    logic                valid_mem [l2_cache_pkg::num_sets][l2_cache_pkg::num_ways];
    logic                dirty_mem [l2_cache_pkg::num_sets][l2_cache_pkg::num_ways];

    l2_cache_pkg::tag_t      req_tag;
    l2_cache_pkg::index_t    req_index;
    l2_cache_pkg::way_mask_t hit_vec;

    assign req_tag   = mem_address[31 -: l2_cache_pkg::tag_bits];
    assign req_index = mem_address[l2_cache_pkg::offset_bits +: l2_cache_pkg::index_bits];

    // compare all four ways of the addressed set
    always_comb
    begin
        for (int w = 0; w < l2_cache_pkg::num_ways; w++)
        begin
            valid_mask[w] = valid_mem[req_index][w];
            hit_vec[w]    = valid_mem[req_index][w] && (tag_mem[req_index][w] == req_tag);
        end
    end

    // at most one way matches, lowest wins anyway
    always_comb
    begin
        hit_way = '0;
        for (int w = l2_cache_pkg::num_ways - 1; w >= 0; w--)
        begin
            if (hit_vec[w])
            begin
                hit_way = l2_cache_pkg::way_t'(w);
            end
        end
    end

    assign hit       = |hit_vec;
    assign mem_rdata = data_mem[req_index][hit_way];

    // victim readout for the controller and the write-back data
    assign victim_dirty = valid_mem[req_index][victim_way] & dirty_mem[req_index][victim_way];
    assign victim_tag   = tag_mem[req_index][victim_way];
    assign victim_data  = data_mem[req_index][victim_way];

    // state bits
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < l2_cache_pkg::num_sets; s++)
            begin
                for (int w = 0; w < l2_cache_pkg::num_ways; w++)
                begin
                    valid_mem[s][w] <= 1'b0;
                    dirty_mem[s][w] <= 1'b0;
                end
            end
        end
        else if (fill_en)
        begin
            // refilled line is clean
            valid_mem[req_index][victim_way] <= 1'b1;
            dirty_mem[req_index][victim_way] <= 1'b0;
        end
        else if (write_en)
        begin
            dirty_mem[req_index][hit_way] <= 1'b1;
        end
    end

    // tag and data payload
    always_ff @(posedge clk)
    begin
        if (fill_en)
        begin
            tag_mem[req_index][victim_way]  <= req_tag;
            data_mem[req_index][victim_way] <= pmem_rdata;
        end
        else if (write_en)
        begin
            data_mem[req_index][hit_way] <= mem_wdata;
        end
    end

endmodule

`default_nettype wire

//--- verif/l2_cache_properties.sv
// ##########################################################
// handshake assertions for the cache controller FSM;
// bound into the controller from the testbench
// ##########################################################

`timescale 1ns/10ps
`default_nettype none

module l2_cache_properties
(
    input logic clk,
    input logic rst,
    input logic mem_read,
    input logic mem_write,
    input logic mem_resp,
    input logic pmem_read,
    input logic pmem_write,
    input logic pmem_resp,
    input logic fill_en,
    input logic write_en,
    input logic plru_update,
    input logic miss_event
);

    // number of failed assertions so far
    int fail_count = 0;

    // memory port does one thing at a time
    no_read_and_write: assert property (@(posedge clk) disable iff (rst)
        !(pmem_read && pmem_write))
        else
        begin
            $error("pmem_read and pmem_write high together");
            fail_count++;
        end

    // answer only while the CPU still holds its request
    resp_needs_request: assert property (@(posedge clk) disable iff (rst)
        mem_resp |-> (mem_read || mem_write))
        else
        begin
            $error("mem_resp without a held request");
            fail_count++;
        end

    pmem_read_holds: assert property (@(posedge clk) disable iff (rst)
        (pmem_read && !pmem_resp) |=> pmem_read)
        else
        begin
            $error("pmem_read dropped before pmem_resp");
            fail_count++;
        end

    pmem_write_holds: assert property (@(posedge clk) disable iff (rst)
        (pmem_write && !pmem_resp) |=> pmem_write)
        else
        begin
            $error("pmem_write dropped before pmem_resp");
            fail_count++;
        end

    // everything quiet one cycle into reset
    quiet_after_reset: assert property (@(posedge clk)
        rst |=> !(mem_resp || pmem_read || pmem_write || fill_en ||
                  write_en || plru_update || miss_event))
        else
        begin
            $error("handshake output high right after reset");
            fail_count++;
        end

endmodule

`default_nettype wire

//--- verif/l2_cache_tb.sv
// ##########################################################
// testbench for the four-way write-back cache; drives CPU
// requests, models memory with random latency and checks
// every response against a reference cache model
// ##########################################################

`timescale 1ns/10ps
`default_nettype none

module l2_cache_tb;

    localparam int resp_timeout = 200;

    logic                 clk;
    logic                 rst;
    logic                 mem_read;
    logic                 mem_write;
    l2_cache_pkg::addr_t  mem_address;
    l2_cache_pkg::word_t  mem_wdata;
    l2_cache_pkg::word_t  mem_rdata;
    logic                 mem_resp;
    logic                 pmem_read;
    logic                 pmem_write;
    l2_cache_pkg::addr_t  pmem_address;
    l2_cache_pkg::word_t  pmem_wdata;
    l2_cache_pkg::word_t  pmem_rdata;
    logic                 pmem_resp;
    l2_cache_pkg::count_t miss_count;
    logic                 miss_overflow;

    integer seed = 5;
    int     errors = 0;
    int     checks = 0;
    bit     timed_out = 1'b0;

    // memory model contents, traffic and write-back log
    l2_cache_pkg::word_t mem_model [l2_cache_pkg::addr_t];
    int                  mem_txn = 0;
    int                  wb_total = 0;
    l2_cache_pkg::addr_t wb_addr_q [$];
    l2_cache_pkg::word_t wb_data_q [$];

    // reference cache state
    bit                   ref_valid [l2_cache_pkg::num_sets][l2_cache_pkg::num_ways];
    bit                   ref_dirty [l2_cache_pkg::num_sets][l2_cache_pkg::num_ways];
    l2_cache_pkg::tag_t   ref_tag   [l2_cache_pkg::num_sets][l2_cache_pkg::num_ways];
    l2_cache_pkg::word_t  ref_data  [l2_cache_pkg::num_sets][l2_cache_pkg::num_ways];
    l2_cache_pkg::plru_t  ref_plru  [l2_cache_pkg::num_sets];
    l2_cache_pkg::word_t  ref_mem   [l2_cache_pkg::addr_t];
    l2_cache_pkg::count_t exp_miss = '0;
    l2_cache_pkg::addr_t  exp_wb_addr_q [$];
    l2_cache_pkg::word_t  exp_wb_data_q [$];

    // one entry per outstanding response
    string                exp_name_q [$];
    l2_cache_pkg::word_t  exp_data_q [$];
    bit                   exp_read_q [$];
    l2_cache_pkg::count_t exp_cnt_q  [$];

    l2_cache dut0 (
        .clk           (clk),
        .rst           (rst),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .mem_address   (mem_address),
        .mem_wdata     (mem_wdata),
        .mem_rdata     (mem_rdata),
        .mem_resp      (mem_resp),
        .pmem_read     (pmem_read),
        .pmem_write    (pmem_write),
        .pmem_address  (pmem_address),
        .pmem_wdata    (pmem_wdata),
        .pmem_rdata    (pmem_rdata),
        .pmem_resp     (pmem_resp),
        .miss_count    (miss_count),
        .miss_overflow (miss_overflow)
    );

    bind l2_cache_control l2_cache_properties props0 (
        .clk         (clk),
        .rst         (rst),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_resp    (mem_resp),
        .pmem_read   (pmem_read),
        .pmem_write  (pmem_write),
        .pmem_resp   (pmem_resp),
        .fill_en     (fill_en),
        .write_en    (write_en),
        .plru_update (plru_update),
        .miss_event  (miss_event)
    );

    always #4 clk = ~clk;

    // untouched memory, every address bit shows up in the word
    function automatic l2_cache_pkg::word_t fill_pattern(input l2_cache_pkg::addr_t addr);
        return {addr[15:0], addr[31:16]} ^ 32'h9e37_79b9;
    endfunction

    function automatic l2_cache_pkg::addr_t make_addr(input int tag, input int set);
        return {l2_cache_pkg::tag_t'(tag), l2_cache_pkg::index_t'(set), 2'b00};
    endfunction

    // lowest invalid way, else follow the tree away from recent use
    function automatic l2_cache_pkg::way_t ref_victim(input l2_cache_pkg::index_t s);
        for (int w = 0; w < l2_cache_pkg::num_ways; w++)
        begin
            if (!ref_valid[s][w])
            begin
                return l2_cache_pkg::way_t'(w);
            end
        end
        if (ref_plru[s][2] == 1'b0)
        begin
            return ref_plru[s][0] ? 2'd2 : 2'd3;
        end
        return ref_plru[s][1] ? 2'd0 : 2'd1;
    endfunction

    // models one access to completion; returns the expected read word
    function automatic l2_cache_pkg::word_t ref_access(input bit is_write,
                                                       input l2_cache_pkg::addr_t addr,
                                                       input l2_cache_pkg::word_t wdata);
        l2_cache_pkg::tag_t   t;
        l2_cache_pkg::index_t s;
        l2_cache_pkg::addr_t  line;
        int                   way;
        t    = addr[31 -: l2_cache_pkg::tag_bits];
        s    = addr[l2_cache_pkg::offset_bits +: l2_cache_pkg::index_bits];
        line = {t, s, 2'b00};
        way  = -1;
        for (int w = 0; w < l2_cache_pkg::num_ways; w++)
        begin
            if (ref_valid[s][w] && ref_tag[s][w] == t)
            begin
                way = w;
            end
        end
        if (way < 0)
        begin
            exp_miss++;
            way = ref_victim(s);
            // dirty victim goes back to memory first
            if (ref_valid[s][way] && ref_dirty[s][way])
            begin
                exp_wb_addr_q.push_back({ref_tag[s][way], s, 2'b00});
                exp_wb_data_q.push_back(ref_data[s][way]);
                ref_mem[{ref_tag[s][way], s, 2'b00}] = ref_data[s][way];
            end
            ref_valid[s][way] = 1'b1;
            ref_dirty[s][way] = 1'b0;
            ref_tag[s][way]   = t;
            ref_data[s][way]  = ref_mem.exists(line) ? ref_mem[line] : fill_pattern(line);
        end
        if (is_write)
        begin
            ref_data[s][way]  = wdata;
            ref_dirty[s][way] = 1'b1;
        end
        // final lookup hits, tree records the way
        case (way)
            0:       ref_plru[s] = {1'b0, 1'b0, ref_plru[s][0]};
            1:       ref_plru[s] = {1'b0, 1'b1, ref_plru[s][0]};
            2:       ref_plru[s] = {1'b1, ref_plru[s][1], 1'b0};
            default: ref_plru[s] = {1'b1, ref_plru[s][1], 1'b1};
        endcase
        return ref_data[s][way];
    endfunction

    task automatic check_word(input string name, input l2_cache_pkg::word_t expected,
                              input l2_cache_pkg::word_t actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_addr(input string name, input l2_cache_pkg::addr_t expected,
                              input l2_cache_pkg::addr_t actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input l2_cache_pkg::count_t expected,
                               input l2_cache_pkg::count_t actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("ERR %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    // entered on a falling edge, leaves on a falling edge with the request dropped
    task automatic access(input string name, input bit is_write,
                          input l2_cache_pkg::addr_t addr,
                          input l2_cache_pkg::word_t wdata, output int latency);
        l2_cache_pkg::word_t expected;
        int                  cycles;
        latency = 0;
        // a stuck cache gets no further requests
        if (timed_out)
        begin
            return;
        end
        expected = ref_access(is_write, addr, wdata);
        exp_name_q.push_back(name);
        exp_data_q.push_back(expected);
        exp_read_q.push_back(!is_write);
        exp_cnt_q.push_back(exp_miss);
        mem_read    = !is_write;
        mem_write   = is_write;
        mem_address = addr;
        mem_wdata   = wdata;
        cycles      = 0;
        do
        begin
            @(posedge clk);
            cycles++;
        end
        while (!mem_resp && cycles < resp_timeout);
        if (!mem_resp)
        begin
            timed_out = 1'b1;
            errors++;
            $display("timeout, no mem_resp within %0d cycles in %s", resp_timeout, name);
        end
        else
        begin
            latency = cycles;
            @(negedge clk);
            mem_read  = 1'b0;
            mem_write = 1'b0;
        end
    endtask

    // memory side, answers after 1 to 4 cycles with a one-cycle resp
    initial
    begin : memory_model
        int wait_cycles;
        pmem_resp  = 1'b0;
        pmem_rdata = '0;
        forever
        begin
            @(negedge clk);
            pmem_resp = 1'b0;
            if (!rst && (pmem_read || pmem_write))
            begin
                wait_cycles = 1 + ($unsigned($random(seed)) % 4);
                repeat (wait_cycles - 1) @(negedge clk);
                mem_txn++;
                if (pmem_write)
                begin
                    mem_model[pmem_address] = pmem_wdata;
                    wb_addr_q.push_back(pmem_address);
                    wb_data_q.push_back(pmem_wdata);
                    wb_total++;
                end
                else
                begin
                    pmem_rdata = mem_model.exists(pmem_address) ? mem_model[pmem_address]
                                                                : fill_pattern(pmem_address);
                end
                pmem_resp = 1'b1;
            end
        end
    end

    // checks each response and any write-back that came before it
    always @(posedge clk)
    begin : compare_resp
        string name;
        if (!rst && mem_resp)
        begin
            if (exp_name_q.size() == 0)
            begin
                errors++;
                $display("mem_resp arrived with no request outstanding");
            end
            else
            begin
                name = exp_name_q.pop_front();
                if (exp_read_q.pop_front())
                begin
                    check_word(name, exp_data_q.pop_front(), mem_rdata);
                end
                else
                begin
                    void'(exp_data_q.pop_front());
                end
                check_count({name, "_miss_count"}, exp_cnt_q.pop_front(), miss_count);
            end
            while (wb_addr_q.size() > 0 && exp_wb_addr_q.size() > 0)
            begin
                check_addr("writeback_addr", exp_wb_addr_q.pop_front(), wb_addr_q.pop_front());
                check_word("writeback_data", exp_wb_data_q.pop_front(), wb_data_q.pop_front());
            end
        end
    end

    initial
    begin : stimulus
        int                  lat;
        int                  txn_before;
        int                  wb_before;
        l2_cache_pkg::addr_t a;
        l2_cache_pkg::word_t wd;
        clk         = 1'b0;
        rst         = 1'b1;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_address = '0;
        mem_wdata   = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // fresh line misses and fills from memory
        a = make_addr(27'h1a0, 1);
        access("read_miss", 1'b0, a, '0, lat);

        // same line again, one cycle after sampling, no memory traffic
        txn_before = mem_txn;
        access("read_hit", 1'b0, a, '0, lat);
        check_count("hit_latency", 16'd2, l2_cache_pkg::count_t'(lat));
        check_count("hit_traffic", l2_cache_pkg::count_t'(txn_before),
                    l2_cache_pkg::count_t'(mem_txn));

        // write miss allocates, then the read sees the new word
        a = make_addr(27'h2b0, 4);
        access("write_miss", 1'b1, a, 32'hdead_beef, lat);
        access("read_after_write", 1'b0, a, '0, lat);

        // dirty way 0 of set 2 is the victim of the fifth tag
        wb_before = wb_total;
        access("evict_dirty_write", 1'b1, make_addr(27'h300, 2), 32'h1234_5678, lat);
        for (int i = 1; i <= 4; i++)
        begin
            access("evict_fill", 1'b0, make_addr(27'h300 + i, 2), '0, lat);
        end
        check_count("evict_writeback_count", l2_cache_pkg::count_t'(wb_before + 1),
                    l2_cache_pkg::count_t'(wb_total));
        access("evict_reread", 1'b0, make_addr(27'h300, 2), '0, lat);

        // tree order in set 5, the probes miss exactly where predicted
        for (int i = 0; i < 4; i++)
        begin
            access("plru_fill", 1'b0, make_addr(27'h400 + i, 5), '0, lat);
        end
        access("plru_hit_0", 1'b0, make_addr(27'h400, 5), '0, lat);
        access("plru_hit_2", 1'b0, make_addr(27'h402, 5), '0, lat);
        access("plru_new", 1'b0, make_addr(27'h404, 5), '0, lat);
        for (int i = 0; i < 5; i++)
        begin
            access("plru_probe", 1'b0, make_addr(27'h400 + i, 5), '0, lat);
        end

        // random mix over 12 tags and all sets, offset bits random too
        for (int n = 0; n < 300; n++)
        begin
            a       = make_addr(27'h500 + ($unsigned($random(seed)) % 12),
                                $unsigned($random(seed)) % 8);
            a[1:0]  = 2'($random(seed));
            wd      = $random(seed);
            access("random_op", ($random(seed) & 1) != 0, a, wd, lat);
        end
        check_count("final_miss_count", exp_miss, miss_count);
        if (miss_overflow)
        begin
            errors++;
            $display("miss_overflow is set although the count never wrapped");
        end

        @(negedge clk);
        if (exp_name_q.size() != 0)
        begin
            errors++;
            $display("%0d responses never arrived", exp_name_q.size());
        end
        if (wb_addr_q.size() != exp_wb_addr_q.size())
        begin
            errors++;
            $display("memory saw a different number of write-backs than the reference");
        end
        $display("checks %0d errors %0d assertion failures %0d", checks, errors,
                 dut0.control0.props0.fail_count);
        if (errors == 0 && dut0.control0.props0.fail_count == 0)
        begin
            $display("=== PASS ===");
        end
        else
        begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
